//--- hw/bus_timer.sv
`timescale 1ns/1ns

module bus_timer
    import lsu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    logic [TIMER_W-1:0] count;

    // saturates at the limit until run drops.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

    assign expired = run && (count == TIMER_W'(TIMEOUT_CYCLES));

endmodule

//--- hw/dcache.sv
`timescale 1ns/1ns

module dcache
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  waddr_t rd_addr,
    input  logic   we,
    input  waddr_t wr_addr,
    input  word_t  wr_data,
    output word_t  rd_data,
    output logic   hit
);

    logic [CACHE_LINES-1:0] valid;
    tag_t                   tag_mem  [CACHE_LINES];
    word_t                  data_mem [CACHE_LINES];

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t wr_idx;
    tag_t wr_tag;
    logic fwd;

    assign rd_idx = rd_addr[IDX_W-1:0];
    assign rd_tag = rd_addr[IDX_W +: TAG_W];
    assign wr_idx = wr_addr[IDX_W-1:0];
    assign wr_tag = wr_addr[IDX_W +: TAG_W];

    // a write to the line being read is seen by the same lookup.
    assign fwd = we && (wr_idx == rd_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (we) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // replaces whatever address held the line before.
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (fwd) begin
            hit <= wr_tag == rd_tag;
        end else begin
            hit <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= data_mem[rd_idx];
        end
    end

endmodule

//--- hw/lsu_ctrl.sv
`timescale 1ns/1ns

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  issue,
    input  logic  do_load,
    input  logic  do_store,
    input  logic  hit,
    input  logic  uncacheable,
    input  logic  full_mask,
    input  logic  arready,
    input  logic  rvalid,
    input  resp_t rresp,
    input  logic  awready,
    input  logic  wready,
    input  logic  expired,
    output logic  done,
    output logic  access_fault,
    output logic  capture,
    output logic  cache_we,
    output logic  fill_sel,
    output logic  timer_run,
    output logic  arvalid,
    output logic  rready,
    output logic  awvalid,
    output logic  wvalid
);

    lsu_state_t state;
    lsu_state_t state_next;
    lsu_state_t issue_state;

    logic load_miss;
    logic r_ok;
    logic aw_seen;
    logic w_seen;
    logic aw_ok;
    logic w_ok;

    assign load_miss = !hit || uncacheable;
    assign r_ok      = rresp == RESP_OKAY;

    // a channel counts as done in its transfer cycle or after.
    assign aw_ok = aw_seen || (awvalid && awready);
    assign w_ok  = w_seen || (wvalid && wready);

    assign rready    = state == LOAD_PENDING;
    assign fill_sel  = state == LOAD_PENDING;
    assign timer_run = (state == LOAD_PENDING) || (state == STORE_PENDING);
    assign capture   = issue && ((state == IDLE) || done);

    always_comb begin
        done         = 1'b0;
        access_fault = 1'b0;
        cache_we     = 1'b0;
        case (state)
            LOAD_CHECK: begin
                done = !load_miss;
            end
            LOAD_PENDING: begin
                if (rvalid) begin
                    done         = 1'b1;
                    access_fault = !r_ok;
                    cache_we     = r_ok && !uncacheable;
                end else if (expired) begin
                    done         = 1'b1;
                    access_fault = 1'b1;
                end
            end
            STORE_CHECK: begin
                cache_we = !uncacheable && (hit || full_mask);
            end
            STORE_PENDING: begin
                if (aw_ok && w_ok) begin
                    done = 1'b1;
                end else if (expired) begin
                    done         = 1'b1;
                    access_fault = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        if (do_load) begin
            issue_state = LOAD_CHECK;
        end else if (do_store) begin
            issue_state = STORE_CHECK;
        end else begin
            issue_state = IDLE;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (issue) begin
                    state_next = issue_state;
                end
            end
            LOAD_CHECK: begin
                if (load_miss) begin
                    state_next = LOAD_PENDING;
                end
            end
            STORE_CHECK: begin
                state_next = STORE_PENDING;
            end
            default: ;
        endcase
        // back-to-back issue in the done cycle.
        if (done) begin
            state_next = issue ? issue_state : IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if ((state == LOAD_CHECK) && load_miss) begin
            arvalid <= 1'b1;
        end else if (arready || expired) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (state == STORE_CHECK) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (awready || expired) begin
                awvalid <= 1'b0;
            end
            if (wready || expired) begin
                wvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else if (done) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_seen <= 1'b1;
            end
            if (wvalid && wready) begin
                w_seen <= 1'b1;
            end
        end
    end

endmodule

//--- hw/lsu_datapath.sv
`timescale 1ns/1ns

module lsu_datapath
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  logic   capture,
    input  logic   fill_sel,
    input  waddr_t addr,
    input  word_t  store_data,
    input  strb_t  store_mask,
    input  word_t  rd_data,
    input  word_t  rdata,
    output waddr_t rd_addr,
    output waddr_t wr_addr,
    output word_t  wr_data,
    output word_t  load_data,
    output logic   uncacheable,
    output logic   full_mask,
    output baddr_t araddr,
    output baddr_t awaddr,
    output word_t  wdata,
    output strb_t  wstrb
);

    waddr_t addr_buf;
    word_t  data_buf;
    strb_t  mask_buf;
    word_t  merged;

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_buf <= addr;
            data_buf <= store_data;
            mask_buf <= store_mask;
        end
    end

    // new requests look up the cache in their issue cycle.
    assign rd_addr = issue ? addr : addr_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            uncacheable <= 1'b0;
        end else begin
            uncacheable <= (rd_addr & UNCACHEABLE_MASK) != '0;
        end
    end

    // stored bytes over the cached word.
    always_comb begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            merged[i*8 +: 8] = mask_buf[i] ? data_buf[i*8 +: 8] : rd_data[i*8 +: 8];
        end
    end

    assign wr_addr   = addr_buf;
    assign wr_data   = fill_sel ? rdata : merged;
    assign load_data = fill_sel ? rdata : rd_data;
    assign full_mask = mask_buf == '1;

    assign araddr = {addr_buf, 3'b000};
    assign awaddr = {addr_buf, 3'b000};
    assign wdata  = data_buf;
    assign wstrb  = mask_buf;

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

    // data word and its byte enables.
    typedef logic [63:0] word_t;
    typedef logic [7:0]  strb_t;

    // word address inside the core, byte address on the bus.
    typedef logic [12:0] waddr_t;
    typedef logic [15:0] baddr_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // cache geometry, index from the low word address bits.
    localparam int CACHE_LINES = 32;
    localparam int IDX_W       = 5;
    localparam int TAG_W       = 8;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // top word address bit selects the uncacheable region.
    localparam waddr_t UNCACHEABLE_MASK = 13'h1000;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [2:0] {
        IDLE,
        LOAD_CHECK,
        LOAD_PENDING,
        STORE_CHECK,
        STORE_PENDING
    } lsu_state_t;

endpackage

//--- hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  logic   do_load,
    input  logic   do_store,
    input  waddr_t addr,
    input  word_t  store_data,
    input  strb_t  store_mask,
    output logic   done,
    output word_t  load_data,
    output logic   access_fault,
    output logic   arvalid,
    input  logic   arready,
    output baddr_t araddr,
    input  logic   rvalid,
    output logic   rready,
    input  word_t  rdata,
    input  resp_t  rresp,
    output logic   awvalid,
    input  logic   awready,
    output baddr_t awaddr,
    output logic   wvalid,
    input  logic   wready,
    output word_t  wdata,
    output strb_t  wstrb,
    input  logic   bvalid,
    output logic   bready,
    input  resp_t  bresp
);

    logic   cache_we;
    logic   fill_sel;
    logic   capture;
    logic   timer_run;
    logic   expired;
    logic   uncacheable;
    logic   full_mask;
    logic   hit;
    waddr_t rd_addr;
    waddr_t wr_addr;
    word_t  wr_data;
    word_t  rd_data;

    // write responses are always accepted.
    assign bready = 1'b1;

    lsu_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .do_load      (do_load),
        .do_store     (do_store),
        .hit          (hit),
        .uncacheable  (uncacheable),
        .full_mask    (full_mask),
        .arready      (arready),
        .rvalid       (rvalid),
        .rresp        (rresp),
        .awready      (awready),
        .wready       (wready),
        .expired      (expired),
        .done         (done),
        .access_fault (access_fault),
        .capture      (capture),
        .cache_we     (cache_we),
        .fill_sel     (fill_sel),
        .timer_run    (timer_run),
        .arvalid      (arvalid),
        .rready       (rready),
        .awvalid      (awvalid),
        .wvalid       (wvalid)
    );

    bus_timer timer_i (
        .clk     (clk),
        .rst     (rst),
        .run     (timer_run),
        .expired (expired)
    );

    lsu_datapath datapath_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .capture     (capture),
        .fill_sel    (fill_sel),
        .addr        (addr),
        .store_data  (store_data),
        .store_mask  (store_mask),
        .rd_data     (rd_data),
        .rdata       (rdata),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .load_data   (load_data),
        .uncacheable (uncacheable),
        .full_mask   (full_mask),
        .araddr      (araddr),
        .awaddr      (awaddr),
        .wdata       (wdata),
        .wstrb       (wstrb)
    );

    dcache dcache_i (
        .clk     (clk),
        .rst     (rst),
        .rd_addr (rd_addr),
        .we      (cache_we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .hit     (hit)
    );

endmodule

//--- sim/lsu_assertions.sv
`timescale 1ns/1ns

module lsu_assertions
    import lsu_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   issue,
    input logic   do_load,
    input logic   do_store,
    input logic   done,
    input logic   access_fault,
    input logic   arvalid,
    input logic   arready,
    input baddr_t araddr,
    input logic   awvalid,
    input logic   awready,
    input baddr_t awaddr,
    input logic   wvalid,
    input logic   wready,
    input word_t  wdata,
    input strb_t  wstrb,
    input logic   bvalid,
    input resp_t  bresp
);

    logic aborted;

    // a timed out request drops its valids with done.
    assign aborted = done && access_fault;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready && !aborted |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before the ar transfer");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready && !aborted |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before the aw transfer");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready && !aborted |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid, wdata or wstrb changed before the w transfer");

    issue_kind: assert property (@(posedge clk) disable iff (rst)
        issue |-> do_load != do_store)
        else $error("issue without exactly one of do_load and do_store");

    // a second done is only legal for a back-to-back issue.
    done_once: assert property (@(posedge clk) disable iff (rst)
        done && !issue |=> !done)
        else $error("done high for two cycles in one operation");

    bresp_okay: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == RESP_OKAY)
        else $error("write response is not OKAY");

endmodule

bind lsu_top lsu_assertions assertions_i (.*);

//--- sim/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int OP_LIMIT        = 4 * TIMEOUT_CYCLES;
    localparam int NUM_OPS         = 14;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_OPS * (OP_LIMIT + 3) + 100;

    logic   clk;
    logic   rst;
    logic   issue;
    logic   do_load;
    logic   do_store;
    waddr_t addr;
    word_t  store_data;
    strb_t  store_mask;
    logic   done;
    word_t  load_data;
    logic   access_fault;
    logic   arvalid;
    logic   arready;
    baddr_t araddr;
    logic   rvalid;
    logic   rready;
    word_t  rdata;
    resp_t  rresp;
    logic   awvalid;
    logic   awready;
    baddr_t awaddr;
    logic   wvalid;
    logic   wready;
    word_t  wdata;
    strb_t  wstrb;
    logic   bvalid;
    logic   bready;
    resp_t  bresp;

    // bus model settings.
    int     ar_delay;
    int     aw_delay;
    int     w_delay;
    int     r_delay;
    logic   silent;
    resp_t  rresp_cfg;

    // bus model state.
    int         ar_wait;
    int         aw_wait;
    int         w_wait;
    int         r_wait;
    logic       r_pending;
    logic [5:0] r_index;
    logic       aw_have;
    logic       w_have;
    logic [5:0] aw_index;
    word_t      w_data;
    strb_t      w_strb;
    word_t      mem [64];
    baddr_t     ar_log [$];
    baddr_t     aw_log [$];
    int         w_count;
    word_t      last_wdata;
    strb_t      last_wstrb;
    longint     cycle;
    longint     aw_cycle;
    longint     w_cycle;

    // result of the last operation.
    int     res_lat;
    int     res_arv;
    word_t  res_data;
    logic   res_fault;
    longint res_cycle;

    int seed;
    int checks;
    int errors;

    lsu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t m);
        word_t w;
        w = old;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                w[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        return w;
    endfunction

    // slave side of the bus, one memory word per 8 bytes.
    always @(posedge clk) begin
        if (rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            r_pending <= 1'b0;
            ar_wait   <= 0;
            aw_wait   <= 0;
            w_wait    <= 0;
            r_wait    <= 0;
            aw_have = 1'b0;
            w_have  = 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_wait   <= 0;
                r_pending <= 1'b1;
                r_index   <= araddr[8:3];
                ar_log.push_back(araddr);
            end else if (!arvalid) begin
                ar_wait <= 0;
            end else if (!silent) begin
                if (ar_wait >= ar_delay) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait + 1;
                end
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_wait >= r_delay) begin
                    rvalid    <= 1'b1;
                    rdata     <= mem[r_index];
                    rresp     <= rresp_cfg;
                    r_pending <= 1'b0;
                    r_wait    <= 0;
                end else begin
                    r_wait <= r_wait + 1;
                end
            end

            if (awvalid && awready) begin
                awready  <= 1'b0;
                aw_wait  <= 0;
                aw_cycle <= cycle;
                aw_have  = 1'b1;
                aw_index = awaddr[8:3];
                aw_log.push_back(awaddr);
            end else if (!awvalid) begin
                aw_wait <= 0;
            end else if (!silent) begin
                if (aw_wait >= aw_delay) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait + 1;
                end
            end

            if (wvalid && wready) begin
                wready     <= 1'b0;
                w_wait     <= 0;
                w_cycle    <= cycle;
                w_have     = 1'b1;
                w_data     = wdata;
                w_strb     = wstrb;
                last_wdata = wdata;
                last_wstrb = wstrb;
                w_count++;
            end else if (!wvalid) begin
                w_wait <= 0;
            end else if (!silent) begin
                if (w_wait >= w_delay) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait + 1;
                end
            end

            // commit once both halves of the write are in.
            if (aw_have && w_have) begin
                mem[aw_index] = merge_bytes(mem[aw_index], w_data, w_strb);
                aw_have = 1'b0;
                w_have  = 1'b0;
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
            end else begin
                bvalid <= 1'b0;
            end
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic run_op(input logic load, input waddr_t a, input word_t d, input strb_t m);
        int n;
        @(posedge clk);
        issue      <= 1'b1;
        do_load    <= load;
        do_store   <= !load;
        addr       <= a;
        store_data <= d;
        store_mask <= m;
        @(posedge clk);
        issue    <= 1'b0;
        do_load  <= 1'b0;
        do_store <= 1'b0;
        n       = 0;
        res_arv = -1;
        do begin
            @(posedge clk);
            n++;
            if (arvalid && res_arv < 0) begin
                res_arv = n;
            end
        end while (!done && n < OP_LIMIT);
        if (!done) begin
            errors++;
            $display("%s at address 0x%h did not finish within %0d cycles",
                     load ? "load" : "store", a, OP_LIMIT);
        end
        res_lat   = n;
        res_data  = load_data;
        res_fault = access_fault;
        res_cycle = cycle;
        // lets the bus model log and commit the last transfers.
        @(posedge clk);
    endtask

    task automatic load_word(input waddr_t a);
        run_op(1'b1, a, '0, '0);
    endtask

    task automatic store_word(input waddr_t a, input word_t d, input strb_t m);
        run_op(1'b0, a, d, m);
    endtask

    task automatic miss_then_hit();
        waddr_t a;
        word_t  exp;
        int     ar0;
        a   = 13'h0025;
        exp = mem[a[5:0]];
        ar0 = ar_log.size();
        load_word(a);
        check("load_data", res_data, exp);
        check("access_fault", res_fault, 1'b0);
        check("ar transfers", ar_log.size() - ar0, 1);
        check("araddr", ar_log[$], {a, 3'b000});
        ar0 = ar_log.size();
        load_word(a);
        check("load_data", res_data, exp);
        check("hit latency", res_lat, 1);
        check("ar transfers", ar_log.size() - ar0, 0);
    endtask

    task automatic store_and_merge();
        waddr_t a;
        word_t  d;
        word_t  exp;
        int     ar0;
        int     aw0;
        a   = 13'h0025;
        d   = {$random(seed), $random(seed)};
        exp = merge_bytes(mem[a[5:0]], d, 8'h0f);
        aw0 = aw_log.size();
        store_word(a, d, 8'h0f);
        check("access_fault", res_fault, 1'b0);
        check("aw transfers", aw_log.size() - aw0, 1);
        check("awaddr", aw_log[$], {a, 3'b000});
        check("wdata", last_wdata, d);
        check("wstrb", last_wstrb, 8'h0f);
        check("mem", mem[a[5:0]], exp);
        ar0 = ar_log.size();
        load_word(a);
        check("load_data", res_data, exp);
        check("hit latency", res_lat, 1);
        check("ar transfers", ar_log.size() - ar0, 0);

        // a full mask fills a line that was never loaded.
        a = 13'h0047;
        d = {$random(seed), $random(seed)};
        store_word(a, d, 8'hff);
        check("mem", mem[a[5:0]], d);
        ar0 = ar_log.size();
        load_word(a);
        check("load_data", res_data, d);
        check("hit latency", res_lat, 1);
        check("ar transfers", ar_log.size() - ar0, 0);
    endtask

    task automatic uncacheable_loads();
        waddr_t a;
        int     ar0;
        a        = 13'h1009;
        ar_delay = 3;
        for (int k = 0; k < 2; k++) begin
            ar0 = ar_log.size();
            load_word(a);
            check("load_data", res_data, mem[a[5:0]]);
            check("access_fault", res_fault, 1'b0);
            check("ar transfers", ar_log.size() - ar0, 1);
            check("araddr", ar_log[$], {a, 3'b000});
        end
        ar_delay = 0;
    endtask

    task automatic error_response();
        waddr_t a;
        int     ar0;
        a         = 13'h0033;
        rresp_cfg = RESP_SLVERR;
        ar0       = ar_log.size();
        load_word(a);
        check("access_fault", res_fault, 1'b1);
        check("ar transfers", ar_log.size() - ar0, 1);
        rresp_cfg = RESP_OKAY;
        ar0       = ar_log.size();
        load_word(a);
        check("access_fault", res_fault, 1'b0);
        check("load_data", res_data, mem[a[5:0]]);
        check("ar transfers", ar_log.size() - ar0, 1);
    endtask

    task automatic bus_timeout();
        int ar0;
        silent = 1'b1;
        load_word(13'h000a);
        check("access_fault", res_fault, 1'b1);
        check("done after arvalid rise", res_lat - (res_arv - 1), TIMEOUT_CYCLES + 1);
        // the aborted request must not keep its address valid.
        check("arvalid", arvalid, 1'b0);
        silent = 1'b0;
        ar0    = ar_log.size();
        load_word(13'h0011);
        check("access_fault", res_fault, 1'b0);
        check("load_data", res_data, mem[6'h11]);
        check("ar transfers", ar_log.size() - ar0, 1);
    endtask

    task automatic write_backpressure();
        waddr_t a;
        word_t  d;
        strb_t  m;
        word_t  exp;
        int     aw0;
        int     w0;
        for (int k = 0; k < 2; k++) begin
            aw_delay = (k == 0) ? 1 : 5;
            w_delay  = (k == 0) ? 5 : 1;
            a        = (k == 0) ? 13'h0050 : 13'h0061;
            d        = {$random(seed), $random(seed)};
            m        = strb_t'($random(seed));
            exp      = merge_bytes(mem[a[5:0]], d, m);
            aw0      = aw_log.size();
            w0       = w_count;
            store_word(a, d, m);
            check("access_fault", res_fault, 1'b0);
            check("aw transfers", aw_log.size() - aw0, 1);
            check("w transfers", w_count - w0, 1);
            check("done after aw transfer", res_cycle >= aw_cycle, 1'b1);
            check("done after w transfer", res_cycle >= w_cycle, 1'b1);
            check("wstrb", last_wstrb, m);
            check("mem", mem[a[5:0]], exp);
            check("bready", bready, 1'b1);
        end
        aw_delay = 0;
        w_delay  = 0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles and the run did not complete",
                 WATCHDOG_CYCLES);
        $display("%0d checks, %0d errors", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed       = 84824;
        checks     = 0;
        errors     = 0;
        cycle      = 0;
        w_count    = 0;
        rst        = 1'b1;
        issue      = 1'b0;
        do_load    = 1'b0;
        do_store   = 1'b0;
        addr       = '0;
        store_data = '0;
        store_mask = '0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = RESP_OKAY;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bresp      = RESP_OKAY;
        ar_delay   = 0;
        aw_delay   = 0;
        w_delay    = 0;
        r_delay    = 1;
        silent     = 1'b0;
        rresp_cfg  = RESP_OKAY;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {$random(seed), $random(seed)};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        miss_then_hit();
        store_and_merge();
        uncacheable_loads();
        error_response();
        bus_timeout();
        write_backpressure();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/lsu_pkg.sv
hw/dcache.sv
hw/lsu_datapath.sv
hw/bus_timer.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
sim/lsu_assertions.sv
sim/tb_lsu.sv
